/* verilog/rv_pkg.sv */
////////////////////
// Shared constants and encodings for the single-cycle RV32I core.
// Every stage refers to these by scoped name (rv_pkg::...).
// Widths, memory depth and reset address are fixed for a 32-bit core.
////////////////////

package rv_pkg;

  // Datapath and memory sizing
  localparam int XLEN       = 32;
  localparam int IMEM_DEPTH = 64;
  localparam int IMEM_AW    = 6;

  // First fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0100_0000;

  // Base opcodes handled by the core
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;

  // ALU operation
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // Source of the register write value
  typedef enum logic [1:0] {
    WB_ALU,
    WB_PC4,
    WB_NONE
  } wb_sel_e;

  // How the next PC is formed
  typedef enum logic [1:0] {
    FLOW_SEQ,
    FLOW_BRANCH,
    FLOW_JAL,
    FLOW_JALR
  } flow_e;

endpackage : rv_pkg

/* verilog/rv_fetch.sv */
////////////////////
// Fetch stage: program counter and instruction memory.
// The memory is loaded through the write port while reset is held
// and read combinationally at the current PC.
////////////////////

`timescale 1ns/1ps

module rv_fetch (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        imem_we_i,
  input  logic [rv_pkg::IMEM_AW-1:0]  imem_addr_i,
  input  logic [rv_pkg::XLEN-1:0]     imem_data_i,
  input  logic [rv_pkg::XLEN-1:0]     next_pc_i,
  output logic [rv_pkg::XLEN-1:0]     pc_o,
  output logic [rv_pkg::XLEN-1:0]     insn_o
);

  logic [rv_pkg::XLEN-1:0]    pc_q;
  logic [rv_pkg::XLEN-1:0]    pc_off;
  logic [rv_pkg::IMEM_AW-1:0] rd_idx;
  logic [rv_pkg::XLEN-1:0]    imem [rv_pkg::IMEM_DEPTH];

  // PC register
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q <= rv_pkg::RESET_PC;
    end else begin
      pc_q <= next_pc_i;
    end
  end

  // Load port, contents survive reset
  always_ff @(posedge clk) begin
    if (imem_we_i) begin
      imem[imem_addr_i] <= imem_data_i;
    end
  end

  // Word index relative to the reset address, wraps on overflow
  assign pc_off = pc_q - rv_pkg::RESET_PC;
  assign rd_idx = pc_off[rv_pkg::IMEM_AW+1:2];

  assign pc_o   = pc_q;
  assign insn_o = imem[rd_idx];

endmodule : rv_fetch

/* verilog/rv_decode.sv */
////////////////////
// Decode stage: register indices, immediate and control levels.
// Purely combinational; unknown opcodes become a no-op
// with no register write and sequential flow.
////////////////////

`timescale 1ns/1ps

module rv_decode (
  input  logic [rv_pkg::XLEN-1:0] insn_i,
  output logic [4:0]              rs1_o,
  output logic [4:0]              rs2_o,
  output logic [4:0]              rd_o,
  output logic [2:0]              funct3_o,
  output logic [rv_pkg::XLEN-1:0] imm_o,
  output rv_pkg::alu_op_e         alu_op_o,
  output logic                    use_imm_o,
  output logic                    a_is_pc_o,
  output logic                    a_is_zero_o,
  output rv_pkg::wb_sel_e         wb_sel_o,
  output rv_pkg::flow_e           flow_o
);

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic                    f7_b5;
  logic [rv_pkg::XLEN-1:0] imm_i_type;
  logic [rv_pkg::XLEN-1:0] imm_u_type;
  logic [rv_pkg::XLEN-1:0] imm_b_type;
  logic [rv_pkg::XLEN-1:0] imm_j_type;
  rv_pkg::alu_op_e         arith_op;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  assign f7_b5  = insn_i[30];

  assign rd_o     = insn_i[11:7];
  assign rs1_o    = insn_i[19:15];
  assign rs2_o    = insn_i[24:20];
  assign funct3_o = funct3;

  // Sign-extended immediate formats
  assign imm_i_type = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_u_type = {insn_i[31:12], 12'b0};
  assign imm_b_type = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25],
                       insn_i[11:8], 1'b0};
  assign imm_j_type = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20],
                       insn_i[30:21], 1'b0};

  // Arithmetic op for OP and OP-IMM
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == rv_pkg::OP_REG && f7_b5) ? rv_pkg::ALU_SUB
                                                               : rv_pkg::ALU_ADD;
      3'b001:  arith_op = rv_pkg::ALU_SLL;
      3'b010:  arith_op = rv_pkg::ALU_SLT;
      3'b011:  arith_op = rv_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_pkg::ALU_XOR;
      3'b101:  arith_op = f7_b5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  arith_op = rv_pkg::ALU_OR;
      default: arith_op = rv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    // No-op defaults
    imm_o       = imm_i_type;
    alu_op_o    = rv_pkg::ALU_PASS_B;
    use_imm_o   = 1'b0;
    a_is_pc_o   = 1'b0;
    a_is_zero_o = 1'b0;
    wb_sel_o    = rv_pkg::WB_NONE;
    flow_o      = rv_pkg::FLOW_SEQ;
    case (opcode)
      rv_pkg::OP_REG: begin
        alu_op_o = arith_op;
        wb_sel_o = rv_pkg::WB_ALU;
      end
      rv_pkg::OP_IMM: begin
        alu_op_o  = arith_op;
        use_imm_o = 1'b1;
        wb_sel_o  = rv_pkg::WB_ALU;
      end
      rv_pkg::OP_LUI: begin
        imm_o       = imm_u_type;
        alu_op_o    = rv_pkg::ALU_ADD;
        use_imm_o   = 1'b1;
        a_is_zero_o = 1'b1;
        wb_sel_o    = rv_pkg::WB_ALU;
      end
      rv_pkg::OP_AUIPC: begin
        imm_o     = imm_u_type;
        alu_op_o  = rv_pkg::ALU_ADD;
        use_imm_o = 1'b1;
        a_is_pc_o = 1'b1;
        wb_sel_o  = rv_pkg::WB_ALU;
      end
      rv_pkg::OP_BRANCH: begin
        imm_o  = imm_b_type;
        flow_o = rv_pkg::FLOW_BRANCH;
      end
      rv_pkg::OP_JAL: begin
        imm_o     = imm_j_type;
        alu_op_o  = rv_pkg::ALU_ADD;
        use_imm_o = 1'b1;
        a_is_pc_o = 1'b1;
        wb_sel_o  = rv_pkg::WB_PC4;
        flow_o    = rv_pkg::FLOW_JAL;
      end
      rv_pkg::OP_JALR: begin
        // Target is rs1 + imm from the ALU
        alu_op_o  = rv_pkg::ALU_ADD;
        use_imm_o = 1'b1;
        wb_sel_o  = rv_pkg::WB_PC4;
        flow_o    = rv_pkg::FLOW_JALR;
      end
      default: begin
      end
    endcase
  end

endmodule : rv_decode

/* verilog/rv_regfile.sv */
////////////////////
// Integer register file, x1..x31 stored, x0 reads zero.
// Two combinational reads, one write at the clock edge.
////////////////////

`timescale 1ns/1ps

module rv_regfile (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic [4:0]              rs1_i,
  input  logic [4:0]              rs2_i,
  input  logic [4:0]              rd_i,
  input  logic                    we_i,
  input  logic [rv_pkg::XLEN-1:0] wdata_i,
  output logic [rv_pkg::XLEN-1:0] rs1_data_o,
  output logic [rv_pkg::XLEN-1:0] rs2_data_o
);

  logic [rv_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != 5'd0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // Reads see the value before this cycle's write
  assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule : rv_regfile

/* verilog/rv_execute.sv */
////////////////////
// Execute stage: operand selection, ALU and branch compare.
// Purely combinational.
////////////////////

`timescale 1ns/1ps

module rv_execute (
  input  logic [rv_pkg::XLEN-1:0] pc_i,
  input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
  input  logic [rv_pkg::XLEN-1:0] imm_i,
  input  rv_pkg::alu_op_e         alu_op_i,
  input  logic                    use_imm_i,
  input  logic                    a_is_pc_i,
  input  logic                    a_is_zero_i,
  input  logic [2:0]              funct3_i,
  output logic [rv_pkg::XLEN-1:0] alu_res_o,
  output logic                    br_taken_o
);

  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [4:0]              shamt;

  // Operand A: zero for LUI, PC for AUIPC/JAL
  always_comb begin
    if (a_is_zero_i) begin
      op_a = '0;
    end else if (a_is_pc_i) begin
      op_a = pc_i;
    end else begin
      op_a = rs1_data_i;
    end
  end

  assign op_b  = use_imm_i ? imm_i : rs2_data_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op_i)
      rv_pkg::ALU_ADD:  alu_res_o = op_a + op_b;
      rv_pkg::ALU_SUB:  alu_res_o = op_a - op_b;
      rv_pkg::ALU_SLL:  alu_res_o = op_a << shamt;
      rv_pkg::ALU_SLT:  alu_res_o = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU: alu_res_o = {31'b0, op_a < op_b};
      rv_pkg::ALU_XOR:  alu_res_o = op_a ^ op_b;
      rv_pkg::ALU_SRL:  alu_res_o = op_a >> shamt;
      rv_pkg::ALU_SRA:  alu_res_o = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::ALU_OR:   alu_res_o = op_a | op_b;
      rv_pkg::ALU_AND:  alu_res_o = op_a & op_b;
      default:          alu_res_o = op_b;
    endcase
  end

  // Branch condition on the raw register values
  always_comb begin
    case (funct3_i)
      3'b000:  br_taken_o = (rs1_data_i == rs2_data_i);
      3'b001:  br_taken_o = (rs1_data_i != rs2_data_i);
      3'b100:  br_taken_o = ($signed(rs1_data_i) < $signed(rs2_data_i));
      3'b101:  br_taken_o = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      3'b110:  br_taken_o = (rs1_data_i < rs2_data_i);
      3'b111:  br_taken_o = (rs1_data_i >= rs2_data_i);
      default: br_taken_o = 1'b0;
    endcase
  end

endmodule : rv_execute

/* verilog/rv_result.sv */
////////////////////
// Result stage: picks the register write value and the next PC.
// Purely combinational.
////////////////////

`timescale 1ns/1ps

module rv_result (
  input  logic [rv_pkg::XLEN-1:0] pc_i,
  input  logic [rv_pkg::XLEN-1:0] imm_i,
  input  logic [rv_pkg::XLEN-1:0] alu_res_i,
  input  logic                    br_taken_i,
  input  logic [4:0]              rd_i,
  input  rv_pkg::wb_sel_e         wb_sel_i,
  input  rv_pkg::flow_e           flow_i,
  output logic [rv_pkg::XLEN-1:0] next_pc_o,
  output logic                    rf_we_o,
  output logic [4:0]              rf_rd_o,
  output logic [rv_pkg::XLEN-1:0] rf_wdata_o
);

  logic [rv_pkg::XLEN-1:0] pc_plus4;
  logic [rv_pkg::XLEN-1:0] pc_plus_imm;

  assign pc_plus4    = pc_i + 32'd4;
  assign pc_plus_imm = pc_i + imm_i;

  always_comb begin
    case (flow_i)
      rv_pkg::FLOW_BRANCH: next_pc_o = br_taken_i ? pc_plus_imm : pc_plus4;
      rv_pkg::FLOW_JAL:    next_pc_o = pc_plus_imm;
      rv_pkg::FLOW_JALR:   next_pc_o = {alu_res_i[rv_pkg::XLEN-1:1], 1'b0};
      default:             next_pc_o = pc_plus4;
    endcase
  end

  // Links write the return address
  always_comb begin
    case (wb_sel_i)
      rv_pkg::WB_ALU: rf_wdata_o = alu_res_i;
      rv_pkg::WB_PC4: rf_wdata_o = pc_plus4;
      default:        rf_wdata_o = '0;
    endcase
  end

  assign rf_we_o = (wb_sel_i != rv_pkg::WB_NONE) && (rd_i != 5'd0);
  assign rf_rd_o = rd_i;

endmodule : rv_result

/* verilog/rv_core.sv */
////////////////////
// Single-cycle RV32I core top level.
// Load the program through the imem port with rst_n_i low, then
// release reset; one instruction retires per cycle on the retire ports.
////////////////////

`timescale 1ns/1ps

module rv_core (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       imem_we_i,
  input  logic [rv_pkg::IMEM_AW-1:0] imem_addr_i,
  input  logic [rv_pkg::XLEN-1:0]    imem_data_i,
  output logic                       retire_valid_o,
  output logic [rv_pkg::XLEN-1:0]    retire_pc_o,
  output logic [rv_pkg::XLEN-1:0]    retire_insn_o,
  output logic                       retire_we_o,
  output logic [4:0]                 retire_rd_o,
  output logic [rv_pkg::XLEN-1:0]    retire_data_o
);

  // Fetch
  logic [rv_pkg::XLEN-1:0] pc;
  logic [rv_pkg::XLEN-1:0] insn;
  logic [rv_pkg::XLEN-1:0] next_pc;

  // Decode
  logic [4:0]              rs1;
  logic [4:0]              rs2;
  logic [4:0]              rd;
  logic [2:0]              funct3;
  logic [rv_pkg::XLEN-1:0] imm;
  rv_pkg::alu_op_e         alu_op;
  logic                    use_imm;
  logic                    a_is_pc;
  logic                    a_is_zero;
  rv_pkg::wb_sel_e         wb_sel;
  rv_pkg::flow_e           flow;

  // Register file and execute
  logic [rv_pkg::XLEN-1:0] rs1_data;
  logic [rv_pkg::XLEN-1:0] rs2_data;
  logic [rv_pkg::XLEN-1:0] alu_res;
  logic                    br_taken;

  // Writeback
  logic                    rf_we;
  logic [4:0]              rf_rd;
  logic [rv_pkg::XLEN-1:0] rf_wdata;

  rv_fetch u_fetch (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .imem_we_i   (imem_we_i),
    .imem_addr_i (imem_addr_i),
    .imem_data_i (imem_data_i),
    .next_pc_i   (next_pc),
    .pc_o        (pc),
    .insn_o      (insn)
  );

  rv_decode u_decode (
    .insn_i      (insn),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rd_o        (rd),
    .funct3_o    (funct3),
    .imm_o       (imm),
    .alu_op_o    (alu_op),
    .use_imm_o   (use_imm),
    .a_is_pc_o   (a_is_pc),
    .a_is_zero_o (a_is_zero),
    .wb_sel_o    (wb_sel),
    .flow_o      (flow)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rd_i       (rf_rd),
    .we_i       (rf_we),
    .wdata_i    (rf_wdata),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  rv_execute u_execute (
    .pc_i        (pc),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .imm_i       (imm),
    .alu_op_i    (alu_op),
    .use_imm_i   (use_imm),
    .a_is_pc_i   (a_is_pc),
    .a_is_zero_i (a_is_zero),
    .funct3_i    (funct3),
    .alu_res_o   (alu_res),
    .br_taken_o  (br_taken)
  );

  rv_result u_result (
    .pc_i       (pc),
    .imm_i      (imm),
    .alu_res_i  (alu_res),
    .br_taken_i (br_taken),
    .rd_i       (rd),
    .wb_sel_i   (wb_sel),
    .flow_i     (flow),
    .next_pc_o  (next_pc),
    .rf_we_o    (rf_we),
    .rf_rd_o    (rf_rd),
    .rf_wdata_o (rf_wdata)
  );

  // Retire view of the instruction committing at the next edge
  assign retire_valid_o = rst_n_i;
  assign retire_pc_o    = pc;
  assign retire_insn_o  = insn;
  assign retire_we_o    = rf_we;
  assign retire_rd_o    = rf_rd;
  assign retire_data_o  = rf_wdata;

endmodule : rv_core

/* bench/rv_core_tb.sv */
////////////////////
// Testbench for the single-cycle RV32I core.
// Loads the program from bench/rv_cases.txt while reset is held,
// releases reset and checks each retire against the expected list.
////////////////////

`timescale 1ns/1ps

module rv_core_tb;

  localparam string CASES_FILE  = "bench/rv_cases.txt";
  localparam int    WAIT_LIMIT  = 20;
  localparam int    RESET_HOLD  = 8;

  logic                       clk;
  logic                       rst_n_i;
  logic                       imem_we_i;
  logic [rv_pkg::IMEM_AW-1:0] imem_addr_i;
  logic [rv_pkg::XLEN-1:0]    imem_data_i;
  logic                       retire_valid_o;
  logic [rv_pkg::XLEN-1:0]    retire_pc_o;
  logic [rv_pkg::XLEN-1:0]    retire_insn_o;
  logic                       retire_we_o;
  logic [4:0]                 retire_rd_o;
  logic [rv_pkg::XLEN-1:0]    retire_data_o;

  // Program words and expected retires from the cases file
  logic [31:0] prog_words [$];
  string       name_q [$];
  logic [31:0] pc_q [$];
  logic        we_q [$];
  logic [4:0]  rd_q [$];
  logic [31:0] val_q [$];

  int pass_count;
  int fail_count;
  bit run_ok;

  rv_core dut (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .imem_we_i      (imem_we_i),
    .imem_addr_i    (imem_addr_i),
    .imem_data_i    (imem_data_i),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_insn_o  (retire_insn_o),
    .retire_we_o    (retire_we_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

  always #2 clk = ~clk;

  // Only P and R lines carry data
  task automatic read_cases(output bit ok);
    int          fd;
    int          n;
    bit          bad;
    string       line;
    string       tag;
    string       name;
    logic [31:0] word;
    logic [31:0] pc;
    int          we;
    int          rd;
    logic [31:0] val;
    ok  = 1'b0;
    bad = 1'b0;
    fd  = $fopen(CASES_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the cases file %s", CASES_FILE);
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s", tag);
        if (n == 1 && tag == "P") begin
          n = $sscanf(line, "%s %h", tag, word);
          if (n != 2) bad = 1'b1;
          prog_words.push_back(word);
        end else if (n == 1 && tag == "R") begin
          n = $sscanf(line, "%s %s %h %d %d %h", tag, name, pc, we, rd, val);
          if (n != 6) bad = 1'b1;
          name_q.push_back(name);
          pc_q.push_back(pc);
          we_q.push_back(we[0]);
          rd_q.push_back(rd[4:0]);
          val_q.push_back(val);
        end
      end
      $fclose(fd);
      ok = !bad && prog_words.size() > 0 && name_q.size() > 0 &&
           prog_words.size() <= rv_pkg::IMEM_DEPTH;
      if (!ok) begin
        $display("Cases file has a malformed line, no program or no expected retires");
      end
    end
  endtask

  // One status line per finished test
  task automatic tally(input string name, input int errs);
    if (errs == 0) begin
      pass_count++;
      $display("[PASS] %s", name);
    end else begin
      fail_count++;
      $display("Test %s ended with %0d mismatching fields", name, errs);
    end
  endtask

  // Write the program through the load port, reset still low
  task automatic load_program;
    int                         i;
    logic [rv_pkg::IMEM_AW-1:0] addr;
    addr = '0;
    for (i = 0; i < prog_words.size(); i++) begin
      @(posedge clk);
      #1;
      imem_we_i   = 1'b1;
      imem_addr_i = addr;
      imem_data_i = prog_words[i];
      addr        = addr + 1'b1;
    end
    @(posedge clk);
    #1;
    imem_we_i = 1'b0;
  endtask

  task automatic hold_reset;
    int i;
    int errs;
    errs = 0;
    for (i = 0; i < RESET_HOLD; i++) begin
      @(posedge clk);
      #3;
      if (retire_valid_o !== 1'b0) begin
        $display("[FAIL] reset_hold valid expected 0 actual %b", retire_valid_o);
        errs++;
      end
    end
    tally("reset_hold", errs);
  endtask

  task automatic release_and_wait(output bit ok);
    int cycles;
    @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    // Sample point sits 1 ns before the next edge
    #2;
    cycles = 0;
    while (retire_valid_o !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #3;
      cycles++;
    end
    ok = (retire_valid_o === 1'b1);
    if (!ok) begin
      $display("Timed out after %0d cycles waiting for retire_valid_o", WAIT_LIMIT);
      fail_count++;
    end
  endtask

  task automatic check_retires;
    int i;
    int errs;
    int idx;
    for (i = 0; i < name_q.size(); i++) begin
      if (i > 0) begin
        @(posedge clk);
        #3;
      end
      errs = 0;
      if (retire_valid_o !== 1'b1) begin
        $display("[FAIL] %s valid expected 1 actual %b", name_q[i], retire_valid_o);
        errs++;
      end
      if (retire_pc_o !== pc_q[i]) begin
        $display("[FAIL] %s pc expected %h actual %h", name_q[i], pc_q[i], retire_pc_o);
        errs++;
      end
      // The retired word is the program word at the expected PC
      idx = int'((pc_q[i] - rv_pkg::RESET_PC) >> 2);
      if (idx < 0 || idx >= prog_words.size()) begin
        $display("Test %s expects a PC outside the loaded program", name_q[i]);
        errs++;
      end else if (retire_insn_o !== prog_words[idx]) begin
        $display("[FAIL] %s insn expected %h actual %h", name_q[i], prog_words[idx],
                 retire_insn_o);
        errs++;
      end
      if (retire_we_o !== we_q[i]) begin
        $display("[FAIL] %s we expected %b actual %b", name_q[i], we_q[i], retire_we_o);
        errs++;
      end
      // rd and value matter only for a real write
      if (we_q[i] === 1'b1) begin
        if (retire_rd_o !== rd_q[i]) begin
          $display("[FAIL] %s rd expected %0d actual %0d", name_q[i], rd_q[i], retire_rd_o);
          errs++;
        end
        if (retire_data_o !== val_q[i]) begin
          $display("[FAIL] %s data expected %h actual %h", name_q[i], val_q[i],
                   retire_data_o);
          errs++;
        end
      end
      tally(name_q[i], errs);
    end
  endtask

  task automatic finish_run;
    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  initial begin
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    imem_we_i   = 1'b0;
    imem_addr_i = '0;
    imem_data_i = '0;
    pass_count  = 0;
    fail_count  = 0;
    read_cases(run_ok);
    if (run_ok) begin
      load_program();
      hold_reset();
      release_and_wait(run_ok);
      if (run_ok) begin
        check_retires();
      end
    end else begin
      fail_count++;
    end
    finish_run();
  end

endmodule : rv_core_tb

/* bench/rv_cases.txt */
# P <instruction word, hex> [assembly], loaded from word 0 at 0x01000000
# R <test> <pc hex> <we> <rd> <value hex>, rd and value checked only when we is 1
P 00500093 addi x1, x0, 5
P FFD00113 addi x2, x0, -3
P 002081B3 add  x3, x1, x2
P 40110233 sub  x4, x2, x1
P 001122B3 slt  x5, x2, x1
P 00113333 sltu x6, x2, x1
P 401253B3 sra  x7, x4, x1
P 00125433 srl  x8, x4, x1
P 001264B3 or   x9, x4, x1
P 00114533 xor  x10, x2, x1
P 001175B3 and  x11, x2, x1
P 00409613 slli x12, x1, 4
P 40225693 srai x13, x4, 2
P 12345737 lui  x14, 0x12345
P 00001797 auipc x15, 0x1
P 00708013 addi x0, x1, 7
P 00100833 add  x16, x0, x1
P 00B08463 beq  x1, x11, +8
P 00100F93 addi x31, x0, 1 (skipped)
P 00B09463 bne  x1, x11, +8
P 00114463 blt  x2, x1, +8
P 00100F93 addi x31, x0, 1 (skipped)
P 00115463 bge  x2, x1, +8
P 0020E463 bltu x1, x2, +8
P 00100F93 addi x31, x0, 1 (skipped)
P 0020F463 bgeu x1, x2, +8
P 00208463 beq  x1, x2, +8
P 00209463 bne  x1, x2, +8
P 00100F93 addi x31, x0, 1 (skipped)
P 0020C463 blt  x1, x2, +8
P 0020D463 bge  x1, x2, +8
P 00100F93 addi x31, x0, 1 (skipped)
P 00116463 bltu x2, x1, +8
P 00117463 bgeu x2, x1, +8
P 00100F93 addi x31, x0, 1 (skipped)
P 0080096F jal  x18, +8
P 00100F93 addi x31, x0, 1 (skipped)
P 00D90A67 jalr x20, 13(x18)
P 00100F93 addi x31, x0, 1 (skipped)
P 0FF0000F fence, not supported
P 00800AEF jal  x21, +8
P 0000006F jal  x0, 0
P FE000EE3 beq  x0, x0, -4
R addi_pos    01000000 1 1  00000005
R addi_neg    01000004 1 2  FFFFFFFD
R add         01000008 1 3  00000002
R sub         0100000C 1 4  FFFFFFF8
R slt_neg     01000010 1 5  00000001
R sltu_neg    01000014 1 6  00000000
R sra         01000018 1 7  FFFFFFFF
R srl         0100001C 1 8  07FFFFFF
R or          01000020 1 9  FFFFFFFD
R xor         01000024 1 10 FFFFFFF8
R and         01000028 1 11 00000005
R slli        0100002C 1 12 00000050
R srai        01000030 1 13 FFFFFFFE
R lui         01000034 1 14 12345000
R auipc       01000038 1 15 01001038
R write_x0    0100003C 0 0  00000000
R read_x0     01000040 1 16 00000005
R beq_taken   01000044 0 0  00000000
R bne_not     0100004C 0 0  00000000
R blt_taken   01000050 0 0  00000000
R bge_not     01000058 0 0  00000000
R bltu_taken  0100005C 0 0  00000000
R bgeu_not    01000064 0 0  00000000
R beq_not     01000068 0 0  00000000
R bne_taken   0100006C 0 0  00000000
R blt_not     01000074 0 0  00000000
R bge_taken   01000078 0 0  00000000
R bltu_not    01000080 0 0  00000000
R bgeu_taken  01000084 0 0  00000000
R jal_link    0100008C 1 18 01000090
R jalr_link   01000094 1 20 01000098
R unsupported 0100009C 0 0  00000000
R jal_fwd     010000A0 1 21 010000A4
R beq_back    010000A8 0 0  00000000
R jal_self    010000A4 0 0  00000000
R jal_self2   010000A4 0 0  00000000

/* all.f */
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core.sv
bench/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# Build the core and its testbench with Verilator, run, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/rv_core_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
